// File: cpu_defines.svh
// global sizes and constants for the pipeline, included by the RTL files and the testbench
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and address width
`define WORD_W 32

// register file size, register 0 reads zero
`define REG_N 32
`define REG_AW ($clog2(`REG_N))

// first fetch address after reset
`define RESET_PC 32'h0000_0000
`define HALT_OP 6'h3f

`endif

// File: cpu_pkg.sv
// types shared by the pipeline stages: opcodes, function codes, ALU ops and stage registers
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = `HALT_OP
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } aluop_t;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_EX, FWD_WB
    } fwd_sel_t;

    // decode register, read by execute
    typedef struct packed {
        logic valid;
        logic [`WORD_W-1:0] pc, npc, port_a, port_b, imm_ext;
        logic [`REG_AW-1:0] rs, rt, rw;
        aluop_t aluop;
        logic alu_src, dren, dwen, reg_wen, mem_to_reg;
        logic beq, bne, jump;
        logic [`WORD_W-1:0] jump_addr;
        logic halt;
    } decode_t;

    // execute register, read by the memory stage
    typedef struct packed {
        logic valid;
        logic [`WORD_W-1:0] port_o, store_data;
        logic [`REG_AW-1:0] rw;
        logic dren, dwen, reg_wen, mem_to_reg, halt;
    } execute_t;

    // writeback register, feeds the register file and forwarding
    typedef struct packed {
        logic valid;
        logic [`REG_AW-1:0] rw;
        logic reg_wen;
        logic [`WORD_W-1:0] wdata;
        logic halt;
    } memory_t;

endpackage

// File: cpu_if.sv
// ALU and execute-stage interfaces that link the pipeline blocks inside the CPU
`include "cpu_defines.svh"

interface alu_if;
    cpu_pkg::aluop_t aluop;
    logic [`WORD_W-1:0] porta, portb, oport;
    logic zero, negative, overflow;

    modport alu (input aluop, porta, portb, output oport, zero, negative, overflow);
endinterface

interface execute_if;
    cpu_pkg::decode_t decode_p;
    cpu_pkg::execute_t execute_p;
    cpu_pkg::memory_t memory_p;
    cpu_pkg::fwd_sel_t fwd_a, fwd_b;
    logic [`WORD_W-1:0] fw_execute_data, fw_writeback_data;
    logic [`WORD_W-1:0] branch_target;
    logic freeze, flush, branch_taken;
    logic ihit, dhit;

    modport de (input ihit, freeze, flush, output decode_p);
    modport ex (input decode_p, fwd_a, fwd_b, fw_execute_data, fw_writeback_data,
                input ihit, dhit, freeze,
                output execute_p, branch_taken, branch_target);
    modport mem (input execute_p, ihit, dhit,
                 output memory_p, fw_execute_data, fw_writeback_data);
    modport haz (input decode_p, execute_p, memory_p, dhit, branch_taken,
                 output fwd_a, fwd_b, freeze, flush);
endinterface

// File: alu.sv
// combinational ALU used by the execute stage, with zero, negative and overflow flags
`include "cpu_defines.svh"

module alu (
    alu_if.alu aluif
);
    localparam int MSB = `WORD_W - 1;

    always_comb begin
        aluif.oport = '0;
        aluif.overflow = 1'b0;
        case (aluif.aluop)
            cpu_pkg::ALU_ADD: begin
                aluif.oport = aluif.porta + aluif.portb;
                // same input signs, different result sign
                aluif.overflow = (aluif.porta[MSB] == aluif.portb[MSB]) &&
                                 (aluif.oport[MSB] != aluif.porta[MSB]);
            end
            cpu_pkg::ALU_SUB: begin
                aluif.oport = aluif.porta - aluif.portb;
                aluif.overflow = (aluif.porta[MSB] != aluif.portb[MSB]) &&
                                 (aluif.oport[MSB] != aluif.porta[MSB]);
            end
            cpu_pkg::ALU_AND: aluif.oport = aluif.porta & aluif.portb;
            cpu_pkg::ALU_OR:  aluif.oport = aluif.porta | aluif.portb;
            cpu_pkg::ALU_XOR: aluif.oport = aluif.porta ^ aluif.portb;
            cpu_pkg::ALU_SLT:
                aluif.oport = {{MSB{1'b0}}, $signed(aluif.porta) < $signed(aluif.portb)};
            cpu_pkg::ALU_SLTU:
                aluif.oport = {{MSB{1'b0}}, aluif.porta < aluif.portb};
            // immediate goes to the upper half
            cpu_pkg::ALU_LUI: aluif.oport = {aluif.portb[15:0], 16'h0000};
            default: aluif.oport = '0;
        endcase
    end

    assign aluif.zero = (aluif.oport == '0);
    assign aluif.negative = aluif.oport[MSB];

endmodule

// File: fetch_stage.sv
// fetch stage: program counter, instruction request and the fetch pipeline register
`include "cpu_defines.svh"

module fetch_stage (
    input  logic CLK, nRST,
    input  logic ihit, freeze, flush, halt, branch_taken,
    input  logic [`WORD_W-1:0] branch_target,
    input  logic [`WORD_W-1:0] iload,
    output logic [`WORD_W-1:0] iaddr,
    output logic iren,
    output logic [`WORD_W-1:0] fetch_instr, fetch_pc,
    output logic fetch_valid
);
    logic [`WORD_W-1:0] pc;
    logic advance;

    assign advance = ihit & ~freeze & ~halt;
    assign iaddr = pc;
    assign iren = ~halt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `RESET_PC;
            fetch_instr <= '0;
            fetch_pc <= '0;
            fetch_valid <= 1'b0;
        end else if (advance) begin
            pc <= branch_taken ? branch_target : pc + `WORD_W'(4);
            // squash the wrong-path word on a redirect
            fetch_instr <= flush ? '0 : iload;
            fetch_pc <= flush ? '0 : pc;
            fetch_valid <= ~flush;
        end
    end

endmodule

// File: decode_stage.sv
// decode stage: control decoder, register file, immediate extension and the decode register
`include "cpu_defines.svh"

module decode_stage (
    input  logic CLK, nRST,
    input  logic [`WORD_W-1:0] fetch_instr, fetch_pc,
    input  logic fetch_valid,
    execute_if.de exif,
    input  cpu_pkg::memory_t wb
);
    logic [`WORD_W-1:0] regs [`REG_N];
    logic [`WORD_W-1:0] rd_a, rd_b;
    logic [`WORD_W-1:0] held_a, held_b;
    logic [`REG_AW-1:0] rs, rt, rd;
    logic [15:0] imm;
    logic zext;
    cpu_pkg::decode_t nxt;

    assign rs = fetch_instr[25:21];
    assign rt = fetch_instr[20:16];
    assign rd = fetch_instr[15:11];
    assign imm = fetch_instr[15:0];

    // written on the falling edge so this cycle's writeback is read back in time
    always_ff @(negedge CLK) begin
        if (wb.valid && wb.reg_wen && wb.rw != '0) begin
            regs[wb.rw] <= wb.wdata;
        end
    end

    assign rd_a = (rs == '0) ? '0 : regs[rs];
    assign rd_b = (rt == '0) ? '0 : regs[rt];

    // sources of a held instruction, an older result may retire while it waits
    assign held_a = (exif.decode_p.rs == '0) ? '0 : regs[exif.decode_p.rs];
    assign held_b = (exif.decode_p.rt == '0) ? '0 : regs[exif.decode_p.rt];

    always_comb begin
        nxt = '0;
        zext = 1'b0;
        nxt.valid = fetch_valid;
        nxt.pc = fetch_pc;
        nxt.npc = fetch_pc + `WORD_W'(4);
        nxt.port_a = rd_a;
        nxt.port_b = rd_b;
        nxt.rs = rs;
        nxt.rt = rt;
        nxt.jump_addr = {nxt.npc[`WORD_W-1 -: 4], fetch_instr[25:0], 2'b00};
        nxt.aluop = cpu_pkg::ALU_ADD;
        case (cpu_pkg::opcode_t'(fetch_instr[31:26]))
            cpu_pkg::OP_RTYPE: begin
                nxt.rw = rd;
                nxt.reg_wen = 1'b1;
                case (cpu_pkg::funct_t'(fetch_instr[5:0]))
                    cpu_pkg::FN_ADDU: nxt.aluop = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: nxt.aluop = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  nxt.aluop = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   nxt.aluop = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  nxt.aluop = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_SLT:  nxt.aluop = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLTU: nxt.aluop = cpu_pkg::ALU_SLTU;
                    // unknown funct acts as a nop
                    default: nxt.reg_wen = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI, cpu_pkg::OP_ANDI,
            cpu_pkg::OP_ORI, cpu_pkg::OP_LUI: begin
                nxt.rw = rt;
                nxt.reg_wen = 1'b1;
                nxt.alu_src = 1'b1;
                case (cpu_pkg::opcode_t'(fetch_instr[31:26]))
                    cpu_pkg::OP_SLTI: nxt.aluop = cpu_pkg::ALU_SLT;
                    cpu_pkg::OP_ANDI: nxt.aluop = cpu_pkg::ALU_AND;
                    cpu_pkg::OP_ORI:  nxt.aluop = cpu_pkg::ALU_OR;
                    cpu_pkg::OP_LUI:  nxt.aluop = cpu_pkg::ALU_LUI;
                    default:          nxt.aluop = cpu_pkg::ALU_ADD;
                endcase
                zext = (fetch_instr[31:26] == cpu_pkg::OP_ANDI) ||
                       (fetch_instr[31:26] == cpu_pkg::OP_ORI);
            end
            cpu_pkg::OP_LW: begin
                nxt.rw = rt;
                nxt.reg_wen = 1'b1;
                nxt.alu_src = 1'b1;
                nxt.dren = 1'b1;
                nxt.mem_to_reg = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                nxt.alu_src = 1'b1;
                nxt.dwen = 1'b1;
            end
            // compare by subtraction, execute looks at the zero flag
            cpu_pkg::OP_BEQ: begin
                nxt.aluop = cpu_pkg::ALU_SUB;
                nxt.beq = 1'b1;
            end
            cpu_pkg::OP_BNE: begin
                nxt.aluop = cpu_pkg::ALU_SUB;
                nxt.bne = 1'b1;
            end
            cpu_pkg::OP_J:    nxt.jump = 1'b1;
            cpu_pkg::OP_HALT: nxt.halt = 1'b1;
            default: ;
        endcase
        nxt.imm_ext = zext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
        if (!fetch_valid) begin
            nxt = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            exif.decode_p <= '0;
        end else if (exif.ihit && !exif.freeze) begin
            exif.decode_p <= exif.flush ? '0 : nxt;
        end else begin
            exif.decode_p.port_a <= held_a;
            exif.decode_p.port_b <= held_b;
        end
    end

endmodule

// File: execute_stage.sv
// execute stage: operand forwarding, ALU, branch and jump resolution and the execute register
`include "cpu_defines.svh"

module execute_stage (
    input logic CLK, nRST,
    execute_if.ex exif
);
    logic [`WORD_W-1:0] opa, opb;
    logic mem_ready;
    cpu_pkg::execute_t nxt;

    alu_if aluif ();
    alu u_alu (.aluif(aluif));

    always_comb begin
        case (exif.fwd_a)
            cpu_pkg::FWD_EX: opa = exif.fw_execute_data;
            cpu_pkg::FWD_WB: opa = exif.fw_writeback_data;
            default:         opa = exif.decode_p.port_a;
        endcase
        case (exif.fwd_b)
            cpu_pkg::FWD_EX: opb = exif.fw_execute_data;
            cpu_pkg::FWD_WB: opb = exif.fw_writeback_data;
            default:         opb = exif.decode_p.port_b;
        endcase
    end

    assign aluif.aluop = exif.decode_p.aluop;
    assign aluif.porta = opa;
    // immediate wins over any forwarded value
    assign aluif.portb = exif.decode_p.alu_src ? exif.decode_p.imm_ext : opb;

    assign exif.branch_target = exif.decode_p.jump ? exif.decode_p.jump_addr :
        exif.decode_p.npc + {exif.decode_p.imm_ext[`WORD_W-3:0], 2'b00};
    assign exif.branch_taken = exif.decode_p.valid &
        ((exif.decode_p.beq & aluif.zero) | (exif.decode_p.bne & ~aluif.zero) |
         exif.decode_p.jump);

    always_comb begin
        nxt.valid = exif.decode_p.valid;
        nxt.port_o = aluif.oport;
        nxt.store_data = opb;
        nxt.rw = exif.decode_p.rw;
        nxt.dren = exif.decode_p.dren;
        nxt.dwen = exif.decode_p.dwen;
        nxt.reg_wen = exif.decode_p.reg_wen;
        nxt.mem_to_reg = exif.decode_p.mem_to_reg;
        nxt.halt = exif.decode_p.halt;
    end

    // the access in the memory stage is finished or there is none
    assign mem_ready = exif.dhit | ~(exif.execute_p.dren | exif.execute_p.dwen);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            exif.execute_p <= '0;
        end else if (exif.ihit) begin
            if (!exif.freeze) begin
                exif.execute_p <= nxt;
            end else if (mem_ready) begin
                // load-use stall, bubble behind the load
                exif.execute_p <= '0;
            end
        end
    end

endmodule

// File: memory_stage.sv
// memory stage: data-memory request, result select, writeback register and halt flag
`include "cpu_defines.svh"

module memory_stage (
    input  logic CLK, nRST,
    execute_if.mem exif,
    input  logic [`WORD_W-1:0] dload,
    output logic [`WORD_W-1:0] daddr, dstore,
    output logic dren, dwen,
    output cpu_pkg::memory_t wb,
    output logic halt
);
    logic halted;
    logic mem_ready;

    // request held from the execute register until dhit, nothing after halt
    assign daddr = exif.execute_p.port_o;
    assign dstore = exif.execute_p.store_data;
    assign dren = exif.execute_p.dren & ~halt;
    assign dwen = exif.execute_p.dwen & ~halt;
    assign mem_ready = exif.dhit | ~(exif.execute_p.dren | exif.execute_p.dwen);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb <= '0;
        end else if (exif.ihit && mem_ready) begin
            wb.valid <= exif.execute_p.valid;
            wb.rw <= exif.execute_p.rw;
            wb.reg_wen <= exif.execute_p.reg_wen;
            wb.halt <= exif.execute_p.halt;
            wb.wdata <= exif.execute_p.mem_to_reg ? dload : exif.execute_p.port_o;
        end
    end

    // sticky once a HALT has been written back
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halted <= 1'b0;
        end else if (wb.valid && wb.halt) begin
            halted <= 1'b1;
        end
    end

    assign halt = halted | (wb.valid & wb.halt);

    assign exif.memory_p = wb;
    assign exif.fw_execute_data = exif.execute_p.port_o;
    assign exif.fw_writeback_data = wb.wdata;

endmodule

// File: hazard_unit.sv
// hazard unit: forwarding selects, load-use and data-wait freeze, and branch flush
`include "cpu_defines.svh"

module hazard_unit (
    execute_if.haz exif
);
    logic load_use;
    logic mem_wait;

    // newest producer first, register 0 never forwards
    function automatic cpu_pkg::fwd_sel_t pick(
        input logic [`REG_AW-1:0] src,
        input cpu_pkg::execute_t ex,
        input cpu_pkg::memory_t mw
    );
        if (src == '0) begin
            return cpu_pkg::FWD_NONE;
        end
        if (ex.valid && ex.reg_wen && ex.rw == src) begin
            return cpu_pkg::FWD_EX;
        end
        if (mw.valid && mw.reg_wen && mw.rw == src) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign exif.fwd_a = pick(exif.decode_p.rs, exif.execute_p, exif.memory_p);
    assign exif.fwd_b = pick(exif.decode_p.rt, exif.execute_p, exif.memory_p);

    // loaded value is not ready until the load reaches writeback
    assign load_use = exif.decode_p.valid && exif.execute_p.valid &&
                      exif.execute_p.dren && exif.execute_p.reg_wen &&
                      exif.execute_p.rw != '0 &&
                      (exif.execute_p.rw == exif.decode_p.rs ||
                       exif.execute_p.rw == exif.decode_p.rt);

    assign mem_wait = (exif.execute_p.dren | exif.execute_p.dwen) & ~exif.dhit;

    assign exif.freeze = load_use | mem_wait;
    assign exif.flush = exif.branch_taken;

endmodule

// File: cpu_pipeline.sv
// CPU top level: connects the five pipeline stages to the instruction and data memory ports
`include "cpu_defines.svh"

module cpu_pipeline (
    input  logic CLK, nRST,
    output logic [`WORD_W-1:0] iaddr,
    output logic iren,
    input  logic [`WORD_W-1:0] iload,
    input  logic ihit,
    output logic [`WORD_W-1:0] daddr, dstore,
    output logic dren, dwen,
    input  logic [`WORD_W-1:0] dload,
    input  logic dhit,
    output logic halt
);
    logic [`WORD_W-1:0] fetch_instr, fetch_pc;
    logic fetch_valid;
    cpu_pkg::memory_t wb;

    execute_if exif ();

    assign exif.ihit = ihit;
    assign exif.dhit = dhit;

    fetch_stage u_fetch (
        .CLK, .nRST,
        .ihit,
        .freeze(exif.freeze),
        .flush(exif.flush),
        .halt,
        .branch_taken(exif.branch_taken),
        .branch_target(exif.branch_target),
        .iload,
        .iaddr, .iren,
        .fetch_instr, .fetch_pc, .fetch_valid
    );

    decode_stage u_decode (
        .CLK, .nRST,
        .fetch_instr, .fetch_pc, .fetch_valid,
        .exif(exif),
        .wb
    );

    execute_stage u_execute (.CLK, .nRST, .exif(exif));

    memory_stage u_memory (
        .CLK, .nRST,
        .exif(exif),
        .dload,
        .daddr, .dstore, .dren, .dwen,
        .wb,
        .halt
    );

    hazard_unit u_hazard (.exif(exif));

endmodule

// File: tb_clock.sv
// testbench clock and power-on reset source, instantiated inside the CPU testbench
module tb_clock (
    output logic CLK,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge CLK);
        rst_n <= 1'b1;
    end

endmodule

// File: tb_cpu.sv
// CPU testbench: memory models, a table of small programs and a data-memory check per program
`include "cpu_defines.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS = 20;
    localparam int ROW_W = 12;
    localparam logic [5:0] OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI = 6'h0d, OP_LUI = 6'h0f, OP_LW = 6'h23, OP_SW = 6'h2b;
    localparam logic [5:0] FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26, FN_SLT = 6'h2a, FN_SLTU = 6'h2b;

    logic CLK, rst_n, dut_rst_n;
    logic prog_rst_n, ihit, iren, dren, dwen, halt;
    logic dhit = 1'b0;
    logic [`WORD_W-1:0] dload = '0;
    logic [`WORD_W-1:0] iaddr, iload, daddr, dstore, got;
    logic [`WORD_W-1:0] imem [16];
    logic [`WORD_W-1:0] dmem [64];

    // program table
    logic [`WORD_W-1:0] rom [ROWS][ROW_W];
    logic [`WORD_W-1:0] chk_addr [ROWS];
    logic [`WORD_W-1:0] chk_exp [ROWS];
    string names [ROWS];
    logic [`WORD_W-1:0] code [$];
    int n_prog = 0, n_pass = 0, n_fail = 0;
    int seed, lat = 0, wcnt = 0, cycles = 0, limit = 0, late_writes = 0, late_before;
    int late_reads = 0, reads_before;

    tb_clock clkgen (.CLK(CLK), .rst_n(rst_n));

    assign dut_rst_n = rst_n & prog_rst_n;

    cpu_pipeline uut (
        .CLK(CLK), .nRST(dut_rst_n),
        .iaddr(iaddr), .iren(iren), .iload(iload), .ihit(ihit),
        .daddr(daddr), .dstore(dstore), .dren(dren), .dwen(dwen),
        .dload(dload), .dhit(dhit), .halt(halt)
    );

    // instruction memory answers in the same cycle
    assign iload = imem[iaddr[5:2]];

    // data memory with 0 to 3 random wait cycles per request
    always @(posedge CLK) begin
        if (!dut_rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'h5a5a_0000 | 32'(i * 4);
            end
            dhit <= 1'b0;
            wcnt <= 0;
        end else if (dhit) begin
            dhit <= 1'b0;
        end else if (dren || dwen) begin
            if (wcnt >= lat) begin
                dhit <= 1'b1;
                wcnt <= 0;
                lat <= $unsigned($random(seed)) % 4;
                dload <= dmem[daddr[7:2]];
                if (dwen) begin
                    dmem[daddr[7:2]] <= dstore;
                end
            end else begin
                wcnt <= wcnt + 1;
            end
        end
    end

    // any request while halted, writes kept apart from fetches and loads
    always @(posedge CLK) begin
        if (dut_rst_n && halt && dwen) begin
            late_writes <= late_writes + 1;
        end
        if (dut_rst_n && halt && (iren || dren)) begin
            late_reads <= late_reads + 1;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: halt did not rise within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt, rs,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        code.push_back(w);
    endtask

    // ends the program with HALT and a store behind it, files it as one table row
    task automatic close_row(input string name, input logic [31:0] addr, exp);
        emit({`HALT_OP, 26'h0});
        emit(itype(OP_SW, 0, 0, addr[15:0]));
        for (int i = 0; i < ROW_W; i++) begin
            rom[n_prog][i] = (i < code.size()) ? code[i] : '0;
        end
        names[n_prog] = name;
        chk_addr[n_prog] = addr;
        chk_exp[n_prog] = exp;
        n_prog++;
        code.delete();
    endtask

    // r1 = -16, r2 = 0x25, the op writes r3, stored at 0x10
    task automatic alu_row(input string name, input logic [31:0] instr, exp);
        emit(itype(OP_ADDIU, 1, 0, 16'hfff0));
        emit(itype(OP_ADDIU, 2, 0, 16'h0025));
        emit(instr);
        emit(itype(OP_SW, 3, 0, 16'h0010));
        close_row(name, 32'h10, exp);
    endtask

    initial begin
        seed = 32'hebd37923;
        prog_rst_n = 1'b0;
        ihit = 1'b0;
        for (int i = 0; i < 16; i++) begin
            imem[i] = '0;
        end
        alu_row("addiu", itype(OP_ADDIU, 3, 1, 16'h0100), 32'h0000_00f0);
        alu_row("addu", rtype(FN_ADDU, 3, 1, 2), 32'h0000_0015);
        alu_row("subu", rtype(FN_SUBU, 3, 2, 1), 32'h0000_0035);
        alu_row("and", rtype(FN_AND, 3, 1, 2), 32'h0000_0020);
        alu_row("or", rtype(FN_OR, 3, 1, 2), 32'hffff_fff5);
        alu_row("xor", rtype(FN_XOR, 3, 1, 2), 32'hffff_ffd5);
        alu_row("slt", rtype(FN_SLT, 3, 1, 2), 32'h0000_0001);
        alu_row("sltu", rtype(FN_SLTU, 3, 1, 2), 32'h0000_0000);
        alu_row("lui", itype(OP_LUI, 3, 0, 16'hbeef), 32'hbeef_0000);
        alu_row("ori", itype(OP_ORI, 3, 2, 16'h8001), 32'h0000_8025);
        // newer r4 in execute must win over older r4 in writeback
        emit(itype(OP_ADDIU, 4, 0, 16'h0005));
        emit(itype(OP_ADDIU, 4, 4, 16'h0007));
        emit(rtype(FN_ADDU, 5, 4, 4));
        emit(itype(OP_SW, 5, 0, 16'h0014));
        close_row("fwd_ex", 32'h14, 32'h0000_0018);
        emit(itype(OP_ADDIU, 4, 0, 16'h0009));
        emit(itype(OP_ADDIU, 6, 0, 16'h0001));
        emit(rtype(FN_ADDU, 5, 4, 6));
        emit(itype(OP_SW, 5, 0, 16'h0018));
        close_row("fwd_wb", 32'h18, 32'h0000_000a);
        // word 0x20 holds the fill pattern 0x5a5a0020
        emit(itype(OP_ADDIU, 1, 0, 16'h0100));
        emit(itype(OP_LW, 2, 0, 16'h0020));
        emit(rtype(FN_ADDU, 3, 2, 1));
        emit(itype(OP_SW, 3, 0, 16'h0024));
        close_row("load_use", 32'h24, 32'h5a5a_0120);
        emit(itype(OP_ADDIU, 1, 0, 16'h0007));
        emit(itype(OP_ADDIU, 2, 0, 16'h0007));
        emit(itype(OP_BEQ, 2, 1, 16'h0002));
        emit(itype(OP_ADDIU, 1, 0, 16'h0099));
        emit(itype(OP_ADDIU, 1, 0, 16'h0098));
        emit(itype(OP_SW, 1, 0, 16'h0030));
        close_row("beq_taken", 32'h30, 32'h0000_0007);
        emit(itype(OP_ADDIU, 1, 0, 16'h0007));
        emit(itype(OP_ADDIU, 2, 0, 16'h0007));
        emit(itype(OP_BNE, 2, 1, 16'h0002));
        emit(itype(OP_ADDIU, 1, 1, 16'h0001));
        emit(itype(OP_ADDIU, 1, 1, 16'h0002));
        emit(itype(OP_SW, 1, 0, 16'h0030));
        close_row("bne_not_taken", 32'h30, 32'h0000_000a);
        emit(itype(OP_ADDIU, 1, 0, 16'h0003));
        emit({OP_J, 26'd4});
        emit(itype(OP_ADDIU, 1, 0, 16'h0055));
        emit(itype(OP_ADDIU, 1, 0, 16'h0066));
        emit(itype(OP_SW, 1, 0, 16'h0034));
        close_row("jump", 32'h34, 32'h0000_0003);
        emit(itype(OP_ADDIU, 0, 0, 16'h0055));
        emit(rtype(FN_OR, 0, 0, 0));
        emit(itype(OP_SW, 0, 0, 16'h0038));
        close_row("reg_zero", 32'h38, 32'h0000_0000);
        limit = n_prog * 200;

        while (!rst_n) @(posedge CLK);
        for (int p = 0; p < n_prog; p++) begin
            @(posedge CLK);
            prog_rst_n <= 1'b0;
            ihit <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                imem[i] = (i < ROW_W) ? rom[p][i] : '0;
            end
            repeat (2) @(posedge CLK);
            prog_rst_n <= 1'b1;
            ihit <= 1'b1;
            late_before = late_writes;
            reads_before = late_reads;
            @(posedge CLK);
            while (halt !== 1'b1) @(posedge CLK);
            // give a stray write after halt the chance to show up
            repeat (8) @(posedge CLK);
            got = dmem[chk_addr[p][7:2]];
            if (late_writes != late_before) begin
                $display("Fail %s: data write issued after halt", names[p]);
                n_fail++;
            end else if (late_reads != reads_before) begin
                $display("Fail %s: fetch or load requested after halt", names[p]);
                n_fail++;
            end else if (got !== chk_exp[p]) begin
                $display("Fail %s: expected %h, actual %h", names[p], chk_exp[p], got);
                n_fail++;
            end else begin
                $display("Pass %s: %h", names[p], got);
                n_pass++;
            end
        end
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
cpu_pkg.sv
cpu_if.sv
alu.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
cpu_pipeline.sv
tb_clock.sv
tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the CPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpu -f list.f -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
